// ==== common/fifo_pkg.sv ====
// shared types for the single-counter sync FIFO
package fifo_pkg;

   // ------------------------------------------------------------------------
   // accepted operation for the current cycle
   // ------------------------------------------------------------------------
   typedef enum logic [1:0] {
      OP_IDLE = 2'b00,   // nothing accepted
      OP_PUSH = 2'b01,   // write only
      OP_POP  = 2'b10,   // read only
      OP_BOTH = 2'b11    // write and read, count holds
   } fifo_op_e;

   // ------------------------------------------------------------------------
   // level flags, registered
   // ------------------------------------------------------------------------
   typedef struct packed {
      logic full;    // count == depth
      logic afull;   // count >= almost-full threshold
      logic empty;   // count == 0
      logic aempty;  // count <= almost-empty threshold
   } fifo_status_t;

   // ------------------------------------------------------------------------
   // one-cycle strobes, one cycle after the request
   // ------------------------------------------------------------------------
   typedef struct packed {
      logic wack;       // push was taken
      logic dvld;       // read data valid
      logic overflow;   // write refused while full
      logic underflow;  // read refused while empty
   } fifo_event_t;

endpackage

// ==== fifo_sc_top.f ====
+incdir+sim
common/fifo_pkg.sv
hdl/fifo_addr_gen.sv
hdl/fifo_ram.sv
status/fifo_occ_cnt.sv
status/fifo_flags.sv
hdl/fifo_ctrl.sv
hdl/fifo_sc_top.sv
sim/tb_fifo_sc_top.sv

// ==== hdl/fifo_addr_gen.sv ====
`timescale 1ns/1ps

module fifo_addr_gen #(
   parameter int ADDR_W = 10
) (
   input  logic              pos_clk_i,
   input  logic              aresetn_i,
   input  logic              adv_i,
   output logic [ADDR_W-1:0] addr_o
);

   // advance on each accepted op and roll over from the top location to zero
   always_ff @(posedge pos_clk_i or negedge aresetn_i) begin
      if (!aresetn_i) begin
         addr_o <= '0;
      end else if (adv_i) begin
         addr_o <= addr_o + 1'b1;  // depth is a power of two
      end
   end

endmodule

// ==== hdl/fifo_ctrl.sv ====
`timescale 1ns/1ps

module fifo_ctrl (
   input  logic                   pos_clk_i,
   input  logic                   aresetn_i,
   input  logic                   we_i,
   input  logic                   re_i,
   input  fifo_pkg::fifo_status_t status_i,
   output logic                   push_o,
   output logic                   pop_o,
   output fifo_pkg::fifo_op_e     op_o,
   output fifo_pkg::fifo_event_t  event_o
);
   import fifo_pkg::*;

   fifo_event_t event_r;

   // ------------------------------------------------------------------------
   // request qualification
   // ------------------------------------------------------------------------
   // write blocked while full, even with a pop in the same cycle
   assign push_o = we_i & ~status_i.full;
   assign pop_o  = re_i & ~status_i.empty;  // no read from an empty FIFO

   // accepted pair to opcode
   always_comb begin
      unique case ({pop_o, push_o})
         2'b01:   op_o = OP_PUSH;
         2'b10:   op_o = OP_POP;
         2'b11:   op_o = OP_BOTH;   // count stays put
         default: op_o = OP_IDLE;
      endcase
   end

   // ------------------------------------------------------------------------
   // event strobes, one cycle late
   // ------------------------------------------------------------------------
   always_ff @(posedge pos_clk_i or negedge aresetn_i) begin
      if (!aresetn_i) begin
         event_r <= '0;
      end else begin
         event_r.wack      <= push_o;                // ack each accepted write
         event_r.dvld      <= pop_o;                 // matches ram read latency
         event_r.overflow  <= we_i & status_i.full;  // refused write
         event_r.underflow <= re_i & status_i.empty; // refused read
      end
   end

   assign event_o = event_r;

endmodule

// ==== hdl/fifo_ram.sv ====
`timescale 1ns/1ps

module fifo_ram #(
   parameter int DATA_W = 18,
   parameter int ADDR_W = 10
) (
   input  logic              pos_clk_i,
   input  logic              we_i,
   input  logic [ADDR_W-1:0] waddr_i,
   input  logic [DATA_W-1:0] wdata_i,
   input  logic              re_i,
   input  logic [ADDR_W-1:0] raddr_i,
   output logic [DATA_W-1:0] rdata_o
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];  // storage array

   // write port
   always_ff @(posedge pos_clk_i) begin
      if (we_i)
         mem[waddr_i] <= wdata_i;
   end

   // read port, data out one cycle after re_i
   always_ff @(posedge pos_clk_i) begin
      if (re_i)
         rdata_o <= mem[raddr_i];  // holds between reads
   end

endmodule

// ==== hdl/fifo_sc_top.sv ====
`timescale 1ns/1ps

module fifo_sc_top #(
   parameter int DATA_W     = 18,
   parameter int ADDR_W     = 10,
   parameter int AFULL_VAL  = 1020,
   parameter int AEMPTY_VAL = 4
) (
   input  logic                   pos_clk,
   input  logic                   aresetn,
   input  logic                   we_i,
   input  logic [DATA_W-1:0]      wr_data_i,
   input  logic                   re_i,
   output logic [DATA_W-1:0]      rd_data_o,
   output fifo_pkg::fifo_status_t status_o,
   output fifo_pkg::fifo_event_t  event_o,
   output logic [ADDR_W:0]        count_o
);
   import fifo_pkg::*;

   logic              push;        // qualified write
   logic              pop;         // qualified read
   fifo_op_e          op;
   logic [ADDR_W:0]   next_count;  // count after this cycle
   logic [ADDR_W-1:0] waddr;
   logic [ADDR_W-1:0] raddr;

   // ------------------------------------------------------------------------
   // control and status
   // ------------------------------------------------------------------------
   fifo_ctrl i_fifo_ctrl (
      .pos_clk_i (pos_clk),
      .aresetn_i (aresetn),
      .we_i      (we_i),
      .re_i      (re_i),
      .status_i  (status_o),    // flags gate the requests
      .push_o    (push),
      .pop_o     (pop),
      .op_o      (op),
      .event_o   (event_o)
   );

   fifo_occ_cnt #(.ADDR_W(ADDR_W)) i_fifo_occ_cnt (
      .pos_clk_i    (pos_clk),
      .aresetn_i    (aresetn),
      .op_i         (op),
      .next_count_o (next_count),
      .count_o      (count_o)
   );

   fifo_flags #(
      .ADDR_W     (ADDR_W),
      .AFULL_VAL  (AFULL_VAL),
      .AEMPTY_VAL (AEMPTY_VAL)
   ) i_fifo_flags (
      .pos_clk_i    (pos_clk),
      .aresetn_i    (aresetn),
      .op_i         (op),
      .next_count_i (next_count),
      .status_o     (status_o)
   );

   // ------------------------------------------------------------------------
   // memory side
   // ------------------------------------------------------------------------
   fifo_addr_gen #(.ADDR_W(ADDR_W)) i_waddr_gen (
      .pos_clk_i (pos_clk),
      .aresetn_i (aresetn),
      .adv_i     (push),
      .addr_o    (waddr)
   );

   fifo_addr_gen #(.ADDR_W(ADDR_W)) i_raddr_gen (
      .pos_clk_i (pos_clk),
      .aresetn_i (aresetn),
      .adv_i     (pop),
      .addr_o    (raddr)
   );

   fifo_ram #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) i_fifo_ram (
      .pos_clk_i (pos_clk),
      .we_i      (push),
      .waddr_i   (waddr),
      .wdata_i   (wr_data_i),
      .re_i      (pop),
      .raddr_i   (raddr),
      .rdata_o   (rd_data_o)    // lines up with dvld
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FIFO testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_fifo_sc_top -f fifo_sc_top.f \
   --Mdir obj_dir -o tb_fifo_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_fifo_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
   echo "result: pass"
   exit 0
fi
echo "result: fail"
exit 1

// ==== sim/tb_fifo_tests.svh ====
// ---------------------------------------------------------------------------
// one clock of stimulus, checks the previous request's results
// ---------------------------------------------------------------------------
task automatic do_cycle(input logic we, input logic re, input logic [DATA_W-1:0] data);
   logic full_now;
   logic empty_now;
   logic push_ok;
   logic pop_ok;
   @(posedge pos_clk);
   we_i      <= we;
   re_i      <= re;
   wr_data_i <= data;
   @(negedge pos_clk);       // outputs settled from last edge
   if (pending)
      compare_outputs();
   full_now  = (model_q.size() == DEPTH);
   empty_now = (model_q.size() == 0);
   push_ok   = we && !full_now;   // blocked while full, pop or not
   pop_ok    = re && !empty_now;
   exp_ev.wack      = push_ok;
   exp_ev.dvld      = pop_ok;
   exp_ev.overflow  = we && full_now;
   exp_ev.underflow = re && empty_now;
   if (pop_ok)
      exp_data = model_q.pop_front();
   if (push_ok)
      model_q.push_back(data);
   exp_count  = (ADDR_W+1)'(model_q.size());
   exp_status = status_for(model_q.size());
   pending    = 1'b1;
endtask

task automatic test_reset_values();
   int errs_at_start;
   errs_at_start = err_cnt;
   @(negedge pos_clk);
   check("count after reset", 32'(count_o), 32'd0);
   check("status after reset", 32'(status_o), 32'(status_for(0)));  // empty, aempty
   check("events after reset", 32'(event_o), 32'd0);
   finish_test("reset values", errs_at_start);
endtask

task automatic test_fill();
   int          errs_at_start;
   logic [31:0] r;
   errs_at_start = err_cnt;
   for (int i = 0; i < DEPTH; i++) begin
      next_rand(r);
      do_cycle(1'b1, 1'b0, DATA_W'(r));
   end
   do_cycle(1'b1, 1'b0, '1);        // refused, FIFO full
   do_cycle(1'b0, 1'b0, '0);
   check("count held at full", 32'(count_o), 32'(DEPTH));
   check("overflow strobe", 32'(event_o.overflow), 32'd1);
   check("no ack when full", 32'(event_o.wack), 32'd0);
   finish_test("fill", errs_at_start);
endtask

task automatic test_drain();
   int errs_at_start;
   errs_at_start = err_cnt;
   for (int i = 0; i < DEPTH; i++)
      do_cycle(1'b0, 1'b1, '0);     // data order checked per cycle
   do_cycle(1'b0, 1'b1, '0);        // refused, FIFO empty
   do_cycle(1'b0, 1'b0, '0);
   check("count at empty", 32'(count_o), 32'd0);
   check("underflow strobe", 32'(event_o.underflow), 32'd1);
   check("no dvld when empty", 32'(event_o.dvld), 32'd0);
   finish_test("drain", errs_at_start);
endtask

task automatic test_push_pop_mid();
   int          errs_at_start;
   logic [31:0] r;
   errs_at_start = err_cnt;
   for (int i = 0; i < DEPTH / 2; i++) begin
      next_rand(r);
      do_cycle(1'b1, 1'b0, DATA_W'(r));
   end
   for (int i = 0; i < 10; i++) begin
      next_rand(r);
      do_cycle(1'b1, 1'b1, DATA_W'(r));   // count and flags hold
   end
   do_cycle(1'b0, 1'b0, '0);
   check("count after push+pop", 32'(count_o), 32'(DEPTH / 2));
   while (model_q.size() > 0)
      do_cycle(1'b0, 1'b1, '0);
   do_cycle(1'b0, 1'b0, '0);
   finish_test("push and pop", errs_at_start);
endtask

// alternating bias so the FIFO swings between full and empty
task automatic test_random_traffic();
   int          errs_at_start;
   logic [31:0] r;
   logic [31:0] d;
   logic        fill_phase;
   errs_at_start = err_cnt;
   for (int i = 0; i < 600; i++) begin
      fill_phase = ((i / 100) % 2) == 0;
      next_rand(r);
      next_rand(d);
      if (fill_phase)
         do_cycle(r[1:0] != 2'b00, r[3:2] == 2'b00, DATA_W'(d));
      else
         do_cycle(r[1:0] == 2'b00, r[3:2] != 2'b00, DATA_W'(d));
   end
   while (model_q.size() > 0)
      do_cycle(1'b0, 1'b1, '0);
   do_cycle(1'b0, 1'b0, '0);
   finish_test("random traffic", errs_at_start);
endtask

// ==== sim/tb_fifo_sc_top.sv ====
`timescale 1ns/1ps

module tb_fifo_sc_top;
   import fifo_pkg::*;

   localparam int DATA_W     = 18;
   localparam int ADDR_W     = 4;
   localparam int AFULL_VAL  = 12;
   localparam int AEMPTY_VAL = 4;
   localparam int DEPTH      = 1 << ADDR_W;
   // the tests take about 700 cycles in all
   localparam int MAX_CYCLES = 3000;

   logic               pos_clk;
   logic               aresetn;
   logic               we_i;
   logic [DATA_W-1:0]  wr_data_i;
   logic               re_i;
   logic [DATA_W-1:0]  rd_data_o;
   fifo_status_t       status_o;
   fifo_event_t        event_o;
   logic [ADDR_W:0]    count_o;

   logic [DATA_W-1:0]  model_q [$];   // words written and not yet read
   logic [31:0]        rng_state;
   int                 err_cnt;
   int                 check_cnt;
   int                 test_cnt;
   int                 test_fail_cnt;
   int                 cycle_cnt = 0;

   // expected outputs for the request driven one cycle earlier
   logic               pending;
   fifo_event_t        exp_ev;
   fifo_status_t       exp_status;
   logic [ADDR_W:0]    exp_count;
   logic [DATA_W-1:0]  exp_data;

   fifo_sc_top #(
      .DATA_W     (DATA_W),
      .ADDR_W     (ADDR_W),
      .AFULL_VAL  (AFULL_VAL),
      .AEMPTY_VAL (AEMPTY_VAL)
   ) i_fifo_sc_top (
      .pos_clk   (pos_clk),
      .aresetn   (aresetn),
      .we_i      (we_i),
      .wr_data_i (wr_data_i),
      .re_i      (re_i),
      .rd_data_o (rd_data_o),
      .status_o  (status_o),
      .event_o   (event_o),
      .count_o   (count_o)
   );

   initial begin
      pos_clk = 1'b0;
      forever #2 pos_clk = ~pos_clk;   // 4 ns period
   end

   // ------------------------------------------------------------------------
   // run limit
   // ------------------------------------------------------------------------
   always @(posedge pos_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: tests did not finish within %0d clock cycles", MAX_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("[FAIL] t=%0d ns %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
   endtask

   // flags straight from the threshold rules
   function automatic fifo_status_t status_for(input int level);
      fifo_status_t s;
      s.full   = (level == DEPTH);
      s.afull  = (level >= AFULL_VAL);
      s.empty  = (level == 0);
      s.aempty = (level <= AEMPTY_VAL);
      return s;
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_rand(output logic [31:0] r);
      rng_state = xorshift32(rng_state);
      r = rng_state;
   endtask

   task automatic compare_outputs();
      check("count_o", 32'(count_o), 32'(exp_count));
      check("status_o", 32'(status_o), 32'(exp_status));
      check("event_o", 32'(event_o), 32'(exp_ev));
      if (exp_ev.dvld)
         check("rd_data_o", 32'(rd_data_o), 32'(exp_data));  // only valid with dvld
   endtask

   task automatic finish_test(input string name, input int errs_at_start);
      test_cnt++;
      if (err_cnt != errs_at_start) begin
         test_fail_cnt++;
         $display("test %-16s : %0d mismatches", name, err_cnt - errs_at_start);
      end else begin
         $display("test %-16s : ok", name);
      end
   endtask

   `include "tb_fifo_tests.svh"

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      aresetn       = 1'b0;
      we_i          = 1'b0;
      re_i          = 1'b0;
      wr_data_i     = '0;
      pending       = 1'b0;
      rng_state     = 32'hebaf;
      err_cnt       = 0;
      check_cnt     = 0;
      test_cnt      = 0;
      test_fail_cnt = 0;
      repeat (4) @(posedge pos_clk);
      aresetn <= 1'b1;

      test_reset_values();
      test_fill();
      test_drain();
      test_push_pop_mid();
      test_random_traffic();

      $display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
               test_cnt, test_fail_cnt, check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== status/fifo_flags.sv ====
`timescale 1ns/1ps

module fifo_flags #(
   parameter int ADDR_W     = 10,
   parameter int AFULL_VAL  = 1020,
   parameter int AEMPTY_VAL = 4
) (
   input  logic                   pos_clk_i,
   input  logic                   aresetn_i,
   input  fifo_pkg::fifo_op_e     op_i,
   input  logic [ADDR_W:0]        next_count_i,
   output fifo_pkg::fifo_status_t status_o
);
   import fifo_pkg::*;

   localparam int DEPTH = 1 << ADDR_W;
   localparam int CNT_W = ADDR_W + 1;

   // thresholds sized to the count
   localparam logic [CNT_W-1:0] FULL_CNT   = CNT_W'(DEPTH);
   localparam logic [CNT_W-1:0] AFULL_CNT  = CNT_W'(AFULL_VAL);
   localparam logic [CNT_W-1:0] AEMPTY_CNT = CNT_W'(AEMPTY_VAL);

   fifo_status_t status_nxt;  // flags for the updated count
   fifo_status_t status_r;
   logic         load;        // count actually moves

   // ------------------------------------------------------------------------
   // compare the count after update
   // ------------------------------------------------------------------------
   always_comb begin
      status_nxt.full   = (next_count_i == FULL_CNT);
      status_nxt.afull  = (next_count_i >= AFULL_CNT);
      status_nxt.empty  = (next_count_i == '0);
      status_nxt.aempty = (next_count_i <= AEMPTY_CNT);
   end

   // only a lone push or pop changes the count
   assign load = (op_i == OP_PUSH) || (op_i == OP_POP);

   // ------------------------------------------------------------------------
   // flag registers
   // ------------------------------------------------------------------------
   always_ff @(posedge pos_clk_i or negedge aresetn_i) begin
      if (!aresetn_i) begin
         status_r.full   <= 1'b0;
         status_r.afull  <= 1'b0;
         status_r.empty  <= 1'b1;   // reset state is empty
         status_r.aempty <= 1'b1;
      end else if (load) begin
         status_r <= status_nxt;
      end
   end

   assign status_o = status_r;

endmodule

// ==== status/fifo_occ_cnt.sv ====
`timescale 1ns/1ps

module fifo_occ_cnt #(
   parameter int ADDR_W = 10
) (
   input  logic               pos_clk_i,
   input  logic               aresetn_i,
   input  fifo_pkg::fifo_op_e op_i,
   output logic [ADDR_W:0]    next_count_o,
   output logic [ADDR_W:0]    count_o
);
   import fifo_pkg::*;

   logic [ADDR_W:0] count_r;  // one extra bit so depth fits

   // ------------------------------------------------------------------------
   // next occupancy
   // ------------------------------------------------------------------------
   always_comb begin
      unique case (op_i)
         OP_PUSH: next_count_o = count_r + 1'b1;
         OP_POP:  next_count_o = count_r - 1'b1;
         default: next_count_o = count_r;   // idle or both
      endcase
   end

   always_ff @(posedge pos_clk_i or negedge aresetn_i) begin
      if (!aresetn_i)
         count_r <= '0;
      else
         count_r <= next_count_o;
   end

   assign count_o = count_r;

endmodule
